// File: logic/dac_types_pkg.sv
package dac_types_pkg;

    ////////////////////////////////////////
    // channel bank sizing
    ////////////////////////////////////////

    localparam int NUM_CHAN = 8;     // dac channels in the bank
    localparam int SAMPLE_W = 14;    // dac code width
    localparam int DWELL_BITS = 32;  // width of the dwell time input

    ////////////////////////////////////////
    // shared types
    ////////////////////////////////////////

    // one dac code
    typedef logic [SAMPLE_W-1:0] sample_t;

    // one bit per channel
    // request, lock, start and done all use this
    typedef logic [NUM_CHAN-1:0] chan_mask_t;

    // all channel samples, channel 0 sits in the low bits
    typedef logic [NUM_CHAN-1:0][SAMPLE_W-1:0] sample_bus_t;

    // dwell time in clock cycles
    typedef logic [DWELL_BITS-1:0] dwell_t;

    // what the execute stage reports back to the result stage
    typedef struct packed {
        chan_mask_t  done;     // per channel done flags
        sample_bus_t samples;  // held output code of each channel
    } chan_status_t;

endpackage

// File: logic/dac_bank_pkg.sv
package dac_bank_pkg;

    // output bank currently routed to the four dac buses
    typedef enum logic [1:0] {
        BANK_NONE,  // nothing selected yet, outputs at zero
        BANK_X,
        BANK_Y
    } bank_e;

    localparam int NUM_OUT = 4;  // physical dac output buses

    // lock patterns that pick a bank
    localparam dac_types_pkg::chan_mask_t BANK_X_MASK = 8'h0F;
    localparam dac_types_pkg::chan_mask_t BANK_Y_MASK = 8'hF0;

    typedef logic [$clog2(dac_types_pkg::NUM_CHAN)-1:0] chan_idx_t;
    typedef chan_idx_t [NUM_OUT-1:0] route_t;  // entry 0 feeds dac1

    // source channel per output, listed dac4 down to dac1
    localparam route_t BANK_X_ROUTE = {3'd3, 3'd2, 3'd0, 3'd1};  // 1, 0, 2, 3
    localparam route_t BANK_Y_ROUTE = {3'd6, 3'd4, 3'd7, 3'd5};  // 5, 7, 4, 6

    // the four routed output buses
    typedef struct packed {
        dac_types_pkg::sample_t dac1;
        dac_types_pkg::sample_t dac2;
        dac_types_pkg::sample_t dac3;
        dac_types_pkg::sample_t dac4;
    } dac_out_t;

endpackage

// File: logic/dac_req_decode.sv
module dac_req_decode (
    input  logic                      clk,
    input  logic                      rst,
    input  dac_types_pkg::chan_mask_t dac_req,
    input  logic                      ack_clr,
    output dac_types_pkg::chan_mask_t start,
    output dac_types_pkg::chan_mask_t lock,
    output dac_bank_pkg::bank_e       bank
);

    dac_types_pkg::chan_mask_t req_q;  // dac_req one cycle late
    logic                      take;   // request accepted this edge

    ////////////////////////////////////////
    // request edge detect
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_q <= '0;
        end else begin
            req_q <= dac_req;
        end
    end

    // first rise of the mask while the lock is empty
    assign take = (dac_req != '0) && (req_q == '0) && (lock == '0);

    ////////////////////////////////////////
    // lock and start pulse
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lock <= '0;
        end else if (ack_clr) begin
            lock <= '0;        // clear wins over a new request
        end else if (take) begin
            lock <= dac_req;   // hold mask until all channels finish
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start <= '0;
        end else if (take) begin
            start <= dac_req;  // single cycle kick to the channels
        end else begin
            start <= '0;
        end
    end

    ////////////////////////////////////////
    // bank decode
    ////////////////////////////////////////

    // follows the lock one edge later
    // any other pattern keeps the last bank
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank <= dac_bank_pkg::BANK_NONE;
        end else if (lock == dac_bank_pkg::BANK_X_MASK) begin
            bank <= dac_bank_pkg::BANK_X;
        end else if (lock == dac_bank_pkg::BANK_Y_MASK) begin
            bank <= dac_bank_pkg::BANK_Y;
        end
    end

    // a pulse must not restart while the lock it set is still held
    a_start_one_cycle: assert property (
        @(posedge clk) disable iff (rst)
        (start != '0) |=> (start == '0)
    ) else $error("start mask held for more than one cycle");

endmodule

// File: logic/dac_channel.sv
module dac_channel #(
    parameter int DWELL_W = 32  // dwell counter width
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  dac_types_pkg::sample_t  sample_in,
    input  dac_types_pkg::dwell_t   dwell,
    input  logic                    ack_clr,
    output logic                    done,
    output dac_types_pkg::sample_t  sample_out
);

    typedef enum logic [1:0] {
        IDLE,  // waiting for a start pulse
        WAIT,  // counting down the dwell
        DONE   // output updated, waiting for ack_clr
    } state_e;

    state_e                  state;
    logic [DWELL_W-1:0]      count;     // remaining dwell cycles
    dac_types_pkg::sample_t  sample_q;  // code captured on start

    ////////////////////////////////////////
    // dwell fsm
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= IDLE;
            count      <= '0;
            sample_out <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        count <= dwell[DWELL_W-1:0];  // load full dwell
                        state <= WAIT;
                    end
                end
                WAIT: begin
                    if (count == '0) begin
                        sample_out <= sample_q;       // new code reaches the dac
                        state      <= DONE;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                DONE: begin
                    if (ack_clr) begin
                        state <= IDLE;                // sample_out keeps its value
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // payload capture, only taken when a start is accepted
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            sample_q <= sample_in;
        end
    end

    assign done = (state == DONE);

    // the decode lock should block any restart mid dwell
    a_no_start_in_wait: assert property (
        @(posedge clk) disable iff (rst)
        start |-> (state != WAIT)
    ) else $error("start arrived while channel in WAIT");

endmodule

// File: logic/dac_result.sv
module dac_result (
    input  logic                        clk,
    input  logic                        rst,
    input  dac_types_pkg::chan_mask_t   lock,
    input  dac_bank_pkg::bank_e         bank,
    input  dac_types_pkg::chan_status_t status,
    output logic                        ack_clr,
    output logic                        dac_ack,
    output dac_bank_pkg::dac_out_t      dac_out
);

    dac_bank_pkg::route_t route;  // source channels for the active bank

    ////////////////////////////////////////
    // completion
    ////////////////////////////////////////

    // every locked channel has finished
    assign ack_clr = (status.done == lock) && (lock != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dac_ack <= 1'b0;
        end else begin
            dac_ack <= ack_clr;  // one cycle, done flags drop on the same edge
        end
    end

    ////////////////////////////////////////
    // output routing
    ////////////////////////////////////////

    always_comb begin
        case (bank)
            dac_bank_pkg::BANK_X: route = dac_bank_pkg::BANK_X_ROUTE;
            dac_bank_pkg::BANK_Y: route = dac_bank_pkg::BANK_Y_ROUTE;
            default:              route = dac_bank_pkg::BANK_X_ROUTE;  // unused, out is zero
        endcase
    end

    // straight from the held samples, no output register
    always_comb begin
        dac_out = '0;
        if (bank != dac_bank_pkg::BANK_NONE) begin
            dac_out.dac1 = status.samples[route[0]];
            dac_out.dac2 = status.samples[route[1]];
            dac_out.dac3 = status.samples[route[2]];
            dac_out.dac4 = status.samples[route[3]];
        end
    end

    // only started channels may finish, ties lock in decode to done in the channels
    a_done_inside_lock: assert property (
        @(posedge clk) disable iff (rst)
        (status.done & ~lock) == '0
    ) else $error("done flag outside the request lock");

    // ack never fires twice in a row, the clear must reach every channel
    a_ack_single: assert property (
        @(posedge clk) disable iff (rst)
        dac_ack |-> !ack_clr
    ) else $error("ack_clr still high after acknowledge");

endmodule

// File: logic/dac_ctrl.sv
module dac_ctrl #(
    parameter int DWELL_W = 32  // passed to every channel counter
) (
    input  logic                       clk,
    input  logic                       rst,
    input  dac_types_pkg::sample_bus_t dac_val,
    input  dac_types_pkg::chan_mask_t  dac_req,
    input  dac_types_pkg::dwell_t      dac_time,
    output logic                       dac_ack,
    output dac_bank_pkg::dac_out_t     dac_out
);

    dac_types_pkg::chan_mask_t   start;     // per channel kick
    dac_types_pkg::chan_mask_t   lock;      // channels of the request in flight
    dac_bank_pkg::bank_e         bank;
    logic                        ack_clr;   // from the result stage only
    dac_types_pkg::chan_mask_t   done_bus;  // per channel finished
    dac_types_pkg::sample_bus_t  held;      // per channel output code
    dac_types_pkg::chan_status_t status;

    ////////////////////////////////////////
    // decode stage
    ////////////////////////////////////////

    dac_req_decode u_decode (
        .clk     (clk),
        .rst     (rst),
        .dac_req (dac_req),
        .ack_clr (ack_clr),
        .start   (start),
        .lock    (lock),
        .bank    (bank)
    );

    ////////////////////////////////////////
    // execute stage
    ////////////////////////////////////////

    // one dwell timer per dac code
    for (genvar i = 0; i < dac_types_pkg::NUM_CHAN; i++) begin : g_chan
        dac_channel #(
            .DWELL_W (DWELL_W)
        ) u_chan (
            .clk        (clk),
            .rst        (rst),
            .start      (start[i]),
            .sample_in  (dac_val[i]),
            .dwell      (dac_time),  // shared by all channels
            .ack_clr    (ack_clr),
            .done       (done_bus[i]),
            .sample_out (held[i])
        );
    end

    // gather channel state for the result stage
    assign status.done    = done_bus;
    assign status.samples = held;

    ////////////////////////////////////////
    // result stage
    ////////////////////////////////////////

    dac_result u_result (
        .clk     (clk),
        .rst     (rst),
        .lock    (lock),
        .bank    (bank),
        .status  (status),
        .ack_clr (ack_clr),
        .dac_ack (dac_ack),
        .dac_out (dac_out)
    );

endmodule

// File: sim/dac_ctrl_tb.sv
module dac_ctrl_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_PERIOD   = 40;        // ns
    localparam int          RESET_CYCLES = 4;
    localparam int          NUM_ROUNDS   = 12;        // directed plus random requests
    localparam logic [15:0] LFSR_SEED    = 16'd39758;
    localparam int          WATCHDOG_NS  = (NUM_ROUNDS * (7 + 10) + RESET_CYCLES) * CLK_PERIOD;

    logic                         clk;
    logic                         rst;
    dac_types_pkg::sample_bus_t   dac_val;
    dac_types_pkg::chan_mask_t    dac_req;
    dac_types_pkg::dwell_t        dac_time;
    logic                         dac_ack;
    dac_bank_pkg::dac_out_t       dac_out;

    logic [15:0]                  lfsr_state;  // shared random source
    dac_types_pkg::sample_bus_t   model_held;  // codes the channels should hold
    dac_bank_pkg::bank_e          model_bank;  // bank the outputs should follow
    int                           exp_n;       // dwell of the request in flight
    int                           edge_cnt;    // edges since the request edge
    bit                           armed;       // request in flight
    bit                           ack_seen;

    dac_ctrl #(
        .DWELL_W (32)
    ) dut (
        .clk      (clk),
        .rst      (rst),
        .dac_val  (dac_val),
        .dac_req  (dac_req),
        .dac_time (dac_time),
        .dac_ack  (dac_ack),
        .dac_out  (dac_out)
    );

    ////////////////////////////////////////
    // clock, reset, watchdog
    ////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout at %0t ns, dac_ack never came", $time);
        $display("TESTS FAILED");
        $fatal(1, "run stopped by the watchdog");
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    // galois form with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken, msb first
    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val        = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // expected buses per bank
    // bank X is 1 0 2 3 and bank Y is 5 7 4 6
    // no bank gives zero
    function automatic dac_bank_pkg::dac_out_t expect_out(
        input dac_bank_pkg::bank_e        bank,
        input dac_types_pkg::sample_bus_t held
    );
        dac_bank_pkg::dac_out_t o;
        o = '0;
        case (bank)
            dac_bank_pkg::BANK_X: begin
                o.dac1 = held[1];
                o.dac2 = held[0];
                o.dac3 = held[2];
                o.dac4 = held[3];
            end
            dac_bank_pkg::BANK_Y: begin
                o.dac1 = held[5];
                o.dac2 = held[7];
                o.dac3 = held[4];
                o.dac4 = held[6];
            end
            default: ;
        endcase
        return o;
    endfunction

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    // one request with drive, take, optional ignored edge and wait for ack
    task automatic run_round(
        input dac_types_pkg::chan_mask_t mask,
        input bit                        zero_dwell,
        input bit                        extra_edge
    );
        dac_types_pkg::sample_bus_t vals;
        logic [31:0]                bits;
        int                         n;
        for (int i = 0; i < dac_types_pkg::NUM_CHAN; i++) begin
            draw_bits(dac_types_pkg::SAMPLE_W, bits);
            vals[i] = bits[dac_types_pkg::SAMPLE_W-1:0];
        end
        draw_bits(3, bits);
        n = zero_dwell ? 0 : int'(bits[2:0]);
        if (extra_edge && n < 4) begin
            n = n + 4;  // room for the second edge inside the dwell
        end
        @(posedge clk);
        dac_req  <= mask;
        dac_val  <= vals;
        dac_time <= n;
        exp_n = n;
        for (int i = 0; i < dac_types_pkg::NUM_CHAN; i++) begin
            if (mask[i]) begin
                model_held[i] = vals[i];
            end
        end
        if (mask == 8'h0F) begin
            model_bank = dac_bank_pkg::BANK_X;
        end else if (mask == 8'hF0) begin
            model_bank = dac_bank_pkg::BANK_Y;
        end
        @(posedge clk);            // request edge
        dac_req <= '0;
        edge_cnt = 0;
        ack_seen = 1'b0;
        armed    = 1'b1;
        @(posedge clk);            // channels captured and dac_val free again
        if (extra_edge) begin
            for (int i = 0; i < dac_types_pkg::NUM_CHAN; i++) begin
                draw_bits(dac_types_pkg::SAMPLE_W, bits);
                vals[i] = bits[dac_types_pkg::SAMPLE_W-1:0];
            end
            dac_val <= vals;
            dac_req <= 8'hFF;      // ignored while the lock is held
            @(posedge clk);
            dac_req <= '0;
        end
        wait (ack_seen);
        repeat (2) @(posedge clk); // gap shows the pulse is single
    endtask

    ////////////////////////////////////////
    // comparing process
    ////////////////////////////////////////

    // sampled on the falling edge away from the drive edge
    always @(negedge clk) begin
        if (!rst) begin
            if (armed && dac_ack) begin
                assert (edge_cnt == exp_n + 3) else begin
                    $display("[FAIL] %0t ns dac_ack edge count expected %0d actual %0d",
                             $time, exp_n + 3, edge_cnt);
                    abort_run();
                end
                assert (dac_out == expect_out(model_bank, model_held)) else begin
                    $display("[FAIL] %0t ns dac_out expected %h actual %h",
                             $time, expect_out(model_bank, model_held), dac_out);
                    abort_run();
                end
                armed    = 1'b0;
                ack_seen = 1'b1;
            end else if (armed) begin
                edge_cnt = edge_cnt + 1;
            end else begin
                assert (dac_ack == 1'b0) else begin
                    $display("[FAIL] %0t ns dac_ack expected 0 actual 1", $time);
                    abort_run();
                end
            end
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin
        logic [31:0]               pick;
        dac_types_pkg::chan_mask_t mask;
        rst        = 1'b1;
        dac_req    = '0;
        dac_val    = '0;
        dac_time   = '0;
        lfsr_state = LFSR_SEED;
        model_held = '0;
        model_bank = dac_bank_pkg::BANK_NONE;
        exp_n      = 0;
        edge_cnt   = 0;
        armed      = 1'b0;
        ack_seen   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (dac_ack == 1'b0) else begin
            $display("[FAIL] %0t ns dac_ack expected 0 actual %b", $time, dac_ack);
            abort_run();
        end
        assert (dac_out == '0) else begin
            $display("[FAIL] %0t ns dac_out expected %h actual %h", $time,
                     dac_bank_pkg::dac_out_t'('0), dac_out);
            abort_run();
        end

        run_round(8'h0F, 1'b0, 1'b0);  // bank X
        run_round(8'hF0, 1'b0, 1'b0);  // bank Y
        run_round(8'h0F, 1'b0, 1'b0);  // back to X
        run_round(8'h03, 1'b0, 1'b0);  // bank holds while ch 0 and 1 change
        run_round(8'h03, 1'b0, 1'b1);  // ch 2 and 3 must keep old codes
        run_round(8'hF0, 1'b1, 1'b0);  // zero dwell

        // random masks for the rest
        for (int r = 6; r < NUM_ROUNDS; r++) begin
            draw_bits(2, pick);
            if (pick[1:0] == 2'd0) begin
                mask = 8'h0F;
            end else if (pick[1:0] == 2'd1) begin
                mask = 8'hF0;
            end else begin
                draw_bits(8, pick);
                mask = (pick[7:0] == 8'h00) ? 8'h01 : pick[7:0];
            end
            run_round(mask, 1'b0, 1'b0);
        end

        repeat (3) @(posedge clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: all.f
logic/dac_types_pkg.sv
logic/dac_bank_pkg.sv
logic/dac_req_decode.sv
logic/dac_channel.sv
logic/dac_result.sv
logic/dac_ctrl.sv
sim/dac_ctrl_tb.sv
